//--- testbench/retire_vectors.txt
// id valid write rd sel funct3 alu load pc csr rs1 rs2 exp_rs1 exp_rs2
// An address of ff reads a random register that is never written
0_0_1_01_0_0_deadbeef_00000000_00000000_00000000_01_ff_00000000_00000000
0_0_0_00_0_0_00000000_00000000_00000000_00000000_01_02_00000000_00000000
1_1_1_01_0_0_12345678_00000000_00000000_00000000_01_ff_12345678_00000000
1_1_1_02_3_0_00000000_00000000_00000000_cafef00d_02_01_cafef00d_12345678
1_1_1_03_2_0_00000000_00000000_00001000_00000000_ff_03_00000000_00001004
1_1_1_04_1_2_00002000_89abcdef_00000000_00000000_04_02_89abcdef_cafef00d
2_1_1_05_1_0_00003000_f1827394_00000000_00000000_05_04_ffffff94_89abcdef
2_1_1_05_1_0_00003001_f1827394_00000000_00000000_05_05_00000073_00000073
2_1_1_05_1_0_00003002_f1827394_00000000_00000000_05_ff_ffffff82_00000000
2_1_1_05_1_0_00003003_f1827394_00000000_00000000_05_ff_fffffff1_00000000
2_1_1_06_1_4_00003000_f1827394_00000000_00000000_06_05_00000094_fffffff1
2_1_1_06_1_4_00003001_f1827394_00000000_00000000_06_ff_00000073_00000000
2_1_1_06_1_4_00003002_f1827394_00000000_00000000_06_ff_00000082_00000000
2_1_1_06_1_4_00003003_f1827394_00000000_00000000_06_ff_000000f1_00000000
2_1_1_07_1_1_00003000_f1827394_00000000_00000000_07_06_00007394_000000f1
2_1_1_07_1_1_00003002_f1827394_00000000_00000000_07_ff_fffff182_00000000
2_1_1_08_1_5_00003000_f1827394_00000000_00000000_08_07_00007394_fffff182
2_1_1_08_1_5_00003002_f1827394_00000000_00000000_08_07_0000f182_fffff182
3_1_1_00_0_0_ffffffff_00000000_00000000_00000000_00_00_00000000_00000000
3_0_0_00_0_0_00000000_00000000_00000000_00000000_00_01_00000000_12345678
4_1_1_09_0_0_0000aaaa_00000000_00000000_00000000_09_01_0000aaaa_12345678
4_0_1_09_0_0_00000000_00000000_00000000_00000000_09_09_0000aaaa_0000aaaa
5_1_1_0a_0_0_11111111_00000000_00000000_00000000_0a_ff_11111111_00000000
5_0_0_00_0_0_00000000_00000000_00000000_00000000_0a_09_11111111_0000aaaa
5_1_1_0a_0_0_22222222_00000000_00000000_00000000_0a_0a_22222222_22222222
5_1_1_0a_0_0_33333333_00000000_00000000_00000000_0a_ff_33333333_00000000
5_0_0_00_0_0_00000000_00000000_00000000_00000000_0a_0a_33333333_33333333

//--- list.f
+incdir+design
design/riscv_core_pkg.sv
design/mem_wb_register.sv
design/writeback_stage.sv
design/reg_file.sv
design/operand_forward.sv
design/riscv_retire_top.sv
testbench/tb_riscv_retire.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the retire datapath testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tb_riscv_retire -o tb_riscv_retire
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_riscv_retire)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

//--- testbench/tb_riscv_retire.sv
`include "riscv_core_consts.svh"

module tb_riscv_retire;
    timeunit 1ns;
    timeprecision 1ps;

    // One vector line is 59 hex digits, see the column note in the data file
    localparam int VEC_BITS = 236;
    localparam int NUM_VECTORS = 27;
    // Vectors plus the reset cycles plus some slack
    localparam int CYCLE_LIMIT = NUM_VECTORS + 8 + 20;

    logic clk = 1'b0;
    logic rst_n;
    logic valid;
    logic reg_write;
    riscv_core_pkg::reg_addr_t rd_addr;
    riscv_core_pkg::wb_sel_t wb_sel;
    riscv_core_pkg::funct3_t funct3;
    riscv_core_pkg::word_t alu_result;
    riscv_core_pkg::word_t load_data;
    riscv_core_pkg::word_t pc;
    riscv_core_pkg::word_t csr_data;
    riscv_core_pkg::reg_addr_t rs1_addr;
    riscv_core_pkg::reg_addr_t rs2_addr;
    riscv_core_pkg::word_t rs1_data;
    riscv_core_pkg::word_t rs2_data;

    logic [VEC_BITS-1:0] vectors [NUM_VECTORS];
    integer seed = 32'hf5ca;
    int cycle_count = 0;
    int cur_test = 0;
    int tests_done = 0;
    int checks = 0;
    int errors = 0;
    int test_checks = 0;
    int test_errors = 0;

    riscv_retire_top dut (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .valid_i      (valid),
        .rd_addr_i    (rd_addr),
        .reg_write_i  (reg_write),
        .wb_sel_i     (wb_sel),
        .funct3_i     (funct3),
        .alu_result_i (alu_result),
        .load_data_i  (load_data),
        .pc_i         (pc),
        .csr_data_i   (csr_data),
        .rs1_addr_i   (rs1_addr),
        .rs2_addr_i   (rs2_addr),
        .rs1_data_o   (rs1_data),
        .rs2_data_o   (rs2_data)
    );

    always #10 clk = ~clk;

    // Hard stop in case the stimulus loop never reaches its end
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** FAILED ***");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic string name_of(input int id);
        case (id)
            0: return "reset_zero";
            1: return "wb_sources";
            2: return "load_align";
            3: return "x0_write";
            4: return "forwarding";
            5: return "back_to_back";
            default: return "unknown";
        endcase
    endfunction

    // Code ff asks for a random register that the vectors never write
    function automatic riscv_core_pkg::reg_addr_t pick_addr(input logic [7:0] code);
        int pick;
        if (code != 8'hff) begin
            return code[4:0];
        end
        pick = 20 + int'($unsigned($random(seed)) % (`REG_COUNT - 20));
        return pick[4:0];
    endfunction

    task automatic compare_word(input string port, input riscv_core_pkg::word_t expected,
                                input riscv_core_pkg::word_t actual);
        checks++;
        test_checks++;
        if (actual !== expected) begin
            errors++;
            test_errors++;
            $display("Fail %s %s: expected %08h, actual %08h", name_of(cur_test), port,
                     expected, actual);
        end
    endtask

    task automatic report_test();
        tests_done++;
        $display("test %s: %0d checks, %0d errors", name_of(cur_test), test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    // Splits one line into the memory-stage fields and drives them
    task automatic apply_vector(input logic [VEC_BITS-1:0] vec,
                                output riscv_core_pkg::word_t exp1,
                                output riscv_core_pkg::word_t exp2, output int tid);
        logic [3:0] id_n, valid_n, write_n, sel_n, f3_n;
        logic [7:0] rd_b, rs1_b, rs2_b;
        riscv_core_pkg::word_t alu, load, pc_v, csr;
        {id_n, valid_n, write_n, rd_b, sel_n, f3_n, alu, load, pc_v, csr,
         rs1_b, rs2_b, exp1, exp2} = vec;
        tid = int'(id_n);
        valid = valid_n[0];
        reg_write = write_n[0];
        rd_addr = rd_b[4:0];
        wb_sel = sel_n[1:0];
        funct3 = f3_n[2:0];
        alu_result = alu;
        load_data = load;
        pc = pc_v;
        csr_data = csr;
        rs1_addr = pick_addr(rs1_b);
        rs2_addr = pick_addr(rs2_b);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        riscv_core_pkg::word_t exp1;
        riscv_core_pkg::word_t exp2;
        int tid;
        rst_n = 1'b0;
        valid = 1'b0;
        reg_write = 1'b0;
        rd_addr = '0;
        wb_sel = '0;
        funct3 = '0;
        alu_result = '0;
        load_data = '0;
        pc = '0;
        csr_data = '0;
        rs1_addr = '0;
        rs2_addr = '0;
        $readmemh("testbench/retire_vectors.txt", vectors);
        if ($isunknown(vectors[NUM_VECTORS-1])) begin
            $display("The vector file holds fewer lines than the testbench expects");
            errors++;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < NUM_VECTORS; i++) begin
            apply_vector(vectors[i], exp1, exp2, tid);
            if (i > 0 && tid != cur_test) begin
                report_test();
            end
            cur_test = tid;
            // Captured at this edge, so this line is in write-back until the next one
            @(posedge clk);
            #9;
            compare_word("rs1", exp1, rs1_data);
            compare_word("rs2", exp2, rs2_data);
            @(negedge clk);
        end
        report_test();
        $display("tests: %0d, checks: %0d, errors: %0d", tests_done, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- design/riscv_retire_top.sv
`include "riscv_core_consts.svh"

module riscv_retire_top (
    input  logic                    clk_i,
    input  logic                    rst_n_i,

    // Memory-stage result, one per cycle
    input  logic                    valid_i,
    input  riscv_core_pkg::reg_addr_t rd_addr_i,
    input  logic                    reg_write_i,
    input  riscv_core_pkg::wb_sel_t wb_sel_i,
    input  riscv_core_pkg::funct3_t funct3_i,
    input  riscv_core_pkg::word_t   alu_result_i,
    input  riscv_core_pkg::word_t   load_data_i,
    input  riscv_core_pkg::word_t   pc_i,
    input  riscv_core_pkg::word_t   csr_data_i,

    // Execute-stage operand reads
    input  riscv_core_pkg::reg_addr_t rs1_addr_i,
    input  riscv_core_pkg::reg_addr_t rs2_addr_i,
    output riscv_core_pkg::word_t   rs1_data_o,
    output riscv_core_pkg::word_t   rs2_data_o
);

    //////////////////////////////////////////////////////////////////
    // MEM/WB boundary
    //////////////////////////////////////////////////////////////////

    logic                      wb_valid;
    riscv_core_pkg::reg_addr_t wb_rd_addr;
    logic                      wb_reg_write;
    riscv_core_pkg::wb_sel_t   wb_sel;
    riscv_core_pkg::funct3_t   wb_funct3;
    riscv_core_pkg::word_t     wb_alu_result;
    riscv_core_pkg::word_t     wb_load_data;
    riscv_core_pkg::word_t     wb_pc;
    riscv_core_pkg::word_t     wb_csr_data;

    mem_wb_register u_mem_wb_register (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .valid_i      (valid_i),
        .rd_addr_i    (rd_addr_i),
        .reg_write_i  (reg_write_i),
        .wb_sel_i     (wb_sel_i),
        .funct3_i     (funct3_i),
        .alu_result_i (alu_result_i),
        .load_data_i  (load_data_i),
        .pc_i         (pc_i),
        .csr_data_i   (csr_data_i),
        .valid_o      (wb_valid),
        .rd_addr_o    (wb_rd_addr),
        .reg_write_o  (wb_reg_write),
        .wb_sel_o     (wb_sel),
        .funct3_o     (wb_funct3),
        .alu_result_o (wb_alu_result),
        .load_data_o  (wb_load_data),
        .pc_o         (wb_pc),
        .csr_data_o   (wb_csr_data)
    );

    //////////////////////////////////////////////////////////////////
    // Write-back and commit
    //////////////////////////////////////////////////////////////////

    // Commit port fans out to the register file and the bypass
    logic                      write_en;
    riscv_core_pkg::reg_addr_t rd_addr;
    riscv_core_pkg::word_t     rd_data;

    writeback_stage u_writeback_stage (
        .valid_i      (wb_valid),
        .rd_addr_i    (wb_rd_addr),
        .reg_write_i  (wb_reg_write),
        .wb_sel_i     (wb_sel),
        .funct3_i     (wb_funct3),
        .alu_result_i (wb_alu_result),
        .load_data_i  (wb_load_data),
        .pc_i         (wb_pc),
        .csr_data_i   (wb_csr_data),
        .write_en_o   (write_en),
        .rd_addr_o    (rd_addr),
        .rd_data_o    (rd_data)
    );

    //////////////////////////////////////////////////////////////////
    // Register file and operand forwarding
    //////////////////////////////////////////////////////////////////

    riscv_core_pkg::word_t rf_rs1_data;
    riscv_core_pkg::word_t rf_rs2_data;

    reg_file u_reg_file (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .write_en_i (write_en),
        .rd_addr_i  (rd_addr),
        .rd_data_i  (rd_data),
        .rs1_addr_i (rs1_addr_i),
        .rs2_addr_i (rs2_addr_i),
        .rs1_data_o (rf_rs1_data),
        .rs2_data_o (rf_rs2_data)
    );

    // The stored read is one cycle behind the commit, so bypass covers it
    operand_forward u_operand_forward (
        .wb_write_en_i (write_en),
        .wb_rd_addr_i  (rd_addr),
        .wb_rd_data_i  (rd_data),
        .rs1_addr_i    (rs1_addr_i),
        .rs2_addr_i    (rs2_addr_i),
        .rf_rs1_data_i (rf_rs1_data),
        .rf_rs2_data_i (rf_rs2_data),
        .rs1_data_o    (rs1_data_o),
        .rs2_data_o    (rs2_data_o)
    );

endmodule

//--- design/operand_forward.sv
`include "riscv_core_consts.svh"

module operand_forward (
    // Instruction retiring in this cycle
    input  logic                    wb_write_en_i,
    input  riscv_core_pkg::reg_addr_t wb_rd_addr_i,
    input  riscv_core_pkg::word_t   wb_rd_data_i,

    // Execute-stage read requests and the stored values behind them
    input  riscv_core_pkg::reg_addr_t rs1_addr_i,
    input  riscv_core_pkg::reg_addr_t rs2_addr_i,
    input  riscv_core_pkg::word_t   rf_rs1_data_i,
    input  riscv_core_pkg::word_t   rf_rs2_data_i,

    // Resolved operands
    output riscv_core_pkg::word_t   rs1_data_o,
    output riscv_core_pkg::word_t   rs2_data_o
);

    // Pick the retiring value when it targets the register being read
    // The enable already excludes x0, so no zero check is needed here
    function automatic riscv_core_pkg::word_t resolve(
        input riscv_core_pkg::reg_addr_t src_addr,
        input riscv_core_pkg::word_t     stored
    );
        logic hit;
        hit = wb_write_en_i && (wb_rd_addr_i == src_addr);
        return hit ? wb_rd_data_i : stored;
    endfunction

    // Each read port is resolved on its own
    // The retiring fields read inside resolve are part of the sensitivity here
    always_comb begin
        rs1_data_o = resolve(rs1_addr_i, rf_rs1_data_i);
        rs2_data_o = resolve(rs2_addr_i, rf_rs2_data_i);
    end

endmodule

//--- design/reg_file.sv
`include "riscv_core_consts.svh"

module reg_file (
    input  logic                    clk_i,
    input  logic                    rst_n_i,

    // Write port driven by the write-back stage
    input  logic                    write_en_i,
    input  riscv_core_pkg::reg_addr_t rd_addr_i,
    input  riscv_core_pkg::word_t   rd_data_i,

    // Read ports for the execute-stage source operands
    input  riscv_core_pkg::reg_addr_t rs1_addr_i,
    input  riscv_core_pkg::reg_addr_t rs2_addr_i,
    output riscv_core_pkg::word_t   rs1_data_o,
    output riscv_core_pkg::word_t   rs2_data_o
);

    // Storage for every architectural register
    // Entry zero stays at its reset value because write_en never targets it
    riscv_core_pkg::word_t regs [`REG_COUNT];

    //////////////////////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            // Start from a known all-zero architectural state
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en_i) begin
            regs[rd_addr_i] <= rd_data_i;
        end
    end

    //////////////////////////////////////////////////////////////////
    // Read ports
    //////////////////////////////////////////////////////////////////

    // Reads are asynchronous and show the state before the next edge
    // A write in flight is covered by the forwarding unit
    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];

endmodule

//--- design/writeback_stage.sv
`include "riscv_core_consts.svh"

module writeback_stage (
    // Entry held in the MEM/WB register
    input  logic                    valid_i,
    input  riscv_core_pkg::reg_addr_t rd_addr_i,
    input  logic                    reg_write_i,
    input  riscv_core_pkg::wb_sel_t wb_sel_i,
    input  riscv_core_pkg::funct3_t funct3_i,
    input  riscv_core_pkg::word_t   alu_result_i,
    input  riscv_core_pkg::word_t   load_data_i,
    input  riscv_core_pkg::word_t   pc_i,
    input  riscv_core_pkg::word_t   csr_data_i,

    // Commit port, shared by the register file and the forwarding unit
    output logic                    write_en_o,
    output riscv_core_pkg::reg_addr_t rd_addr_o,
    output riscv_core_pkg::word_t   rd_data_o
);

    //////////////////////////////////////////////////////////////////
    // Load alignment
    //////////////////////////////////////////////////////////////////

    // For a load the ALU result is the effective address
    // Its low two bits pick the byte lane inside the fetched word
    logic [1:0]            byte_offset;
    logic [7:0]            load_byte;
    logic [15:0]           load_half;
    riscv_core_pkg::word_t load_aligned;

    assign byte_offset = alu_result_i[1:0];

    // Shift the addressed byte down to bit zero
    assign load_byte = load_data_i[{byte_offset, 3'b000} +: 8];

    // Halfwords are aligned on even addresses, so only bit one matters
    assign load_half = byte_offset[1] ? load_data_i[31:16] : load_data_i[15:0];

    always_comb begin
        case (funct3_i)
            // Signed forms replicate the top bit of the loaded value
            `FUNCT3_LB:  load_aligned = {{(`XLEN-8){load_byte[7]}}, load_byte};
            `FUNCT3_LH:  load_aligned = {{(`XLEN-16){load_half[15]}}, load_half};
            // Unsigned forms fill the upper bits with zero
            `FUNCT3_LBU: load_aligned = {{(`XLEN-8){1'b0}}, load_byte};
            `FUNCT3_LHU: load_aligned = {{(`XLEN-16){1'b0}}, load_half};
            `FUNCT3_LW:  load_aligned = load_data_i;
            // Reserved widths fall back to the raw word
            default:     load_aligned = load_data_i;
        endcase
    end

    //////////////////////////////////////////////////////////////////
    // Result selection and commit
    //////////////////////////////////////////////////////////////////

    always_comb begin
        case (wb_sel_i)
            `WB_SEL_ALU:   rd_data_o = alu_result_i;
            `WB_SEL_MEM:   rd_data_o = load_aligned;
            // Link value is the address of the next sequential instruction
            `WB_SEL_PC_P4: rd_data_o = pc_i + `XLEN'd4;
            `WB_SEL_CSR:   rd_data_o = csr_data_i;
            default:       rd_data_o = alu_result_i;
        endcase
    end

    // A commit needs a real instruction that writes a register
    // Writes aimed at x0 are dropped here once for every consumer
    assign write_en_o = valid_i && reg_write_i && (rd_addr_i != '0);

    assign rd_addr_o = rd_addr_i;

endmodule

//--- design/mem_wb_register.sv
`include "riscv_core_consts.svh"

module mem_wb_register (
    input  logic                    clk_i,
    input  logic                    rst_n_i,

    // Result handed over by the memory stage
    input  logic                    valid_i,
    input  riscv_core_pkg::reg_addr_t rd_addr_i,
    input  logic                    reg_write_i,
    input  riscv_core_pkg::wb_sel_t wb_sel_i,
    input  riscv_core_pkg::funct3_t funct3_i,
    input  riscv_core_pkg::word_t   alu_result_i,
    input  riscv_core_pkg::word_t   load_data_i,
    input  riscv_core_pkg::word_t   pc_i,
    input  riscv_core_pkg::word_t   csr_data_i,

    // Same fields as seen by the write-back stage
    output logic                    valid_o,
    output riscv_core_pkg::reg_addr_t rd_addr_o,
    output logic                    reg_write_o,
    output riscv_core_pkg::wb_sel_t wb_sel_o,
    output riscv_core_pkg::funct3_t funct3_o,
    output riscv_core_pkg::word_t   alu_result_o,
    output riscv_core_pkg::word_t   load_data_o,
    output riscv_core_pkg::word_t   pc_o,
    output riscv_core_pkg::word_t   csr_data_o
);

    // The valid bit is the only control state at this boundary
    // Clearing it turns whatever sits in the payload into a bubble
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // Payload moves forward every cycle since write-back never stalls
    // Its content only matters while the valid bit is set
    always_ff @(posedge clk_i) begin
        rd_addr_o    <= rd_addr_i;
        reg_write_o  <= reg_write_i;
        wb_sel_o     <= wb_sel_i;
        funct3_o     <= funct3_i;
        alu_result_o <= alu_result_i;
        load_data_o  <= load_data_i;
        pc_o         <= pc_i;
        csr_data_o   <= csr_data_i;
    end

endmodule

//--- design/riscv_core_pkg.sv
`include "riscv_core_consts.svh"

package riscv_core_pkg;

    //////////////////////////////////////////////////////////////////
    // Vector types shared by the retire datapath
    //////////////////////////////////////////////////////////////////

    // One integer data word, as held in the register file
    typedef logic [`XLEN-1:0] word_t;

    // Register index, wide enough to address every integer register
    typedef logic [$clog2(`REG_COUNT)-1:0] reg_addr_t;

    // Write-back source selector, coded by the WB_SEL macros
    typedef logic [1:0] wb_sel_t;

    // Load width and signedness field taken from the instruction
    typedef logic [2:0] funct3_t;

endpackage

//--- design/riscv_core_consts.svh
`ifndef RISCV_CORE_CONSTS_SVH
`define RISCV_CORE_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Datapath sizing
//////////////////////////////////////////////////////////////////////

// Width of one integer data word in RV32
`define XLEN 32

// Number of architectural integer registers, x0 included
`define REG_COUNT 32

//////////////////////////////////////////////////////////////////////
// Write-back source selector codes
//////////////////////////////////////////////////////////////////////

// Result straight from the ALU, also used for address-only ops
`define WB_SEL_ALU 2'd0
// Aligned and extended load data from the memory stage
`define WB_SEL_MEM 2'd1
// Link address for JAL and JALR
`define WB_SEL_PC_P4 2'd2
// Old CSR value read by a CSR instruction
`define WB_SEL_CSR 2'd3

//////////////////////////////////////////////////////////////////////
// RV32I load funct3 codes
//////////////////////////////////////////////////////////////////////

`define FUNCT3_LB 3'b000
`define FUNCT3_LH 3'b001
`define FUNCT3_LW 3'b010
`define FUNCT3_LBU 3'b100
`define FUNCT3_LHU 3'b101

`endif
